//--- ladybird_exec.f
rtl/ladybird_config.sv
rtl/ladybird_alu_if.sv
rtl/ladybird_alu.sv
rtl/ladybird_decoder.sv
rtl/ladybird_regfile.sv
rtl/ladybird_imem.sv
rtl/ladybird_pc_counter.sv
rtl/ladybird_control_fsm.sv
rtl/ladybird_exec_top.sv
tb/ladybird_tb.sv

//--- rtl/ladybird_alu.sv
module ladybird_alu (
  ladybird_alu_if.alu alu
);
  import ladybird_config::*;

  localparam int SHAMT_W = $clog2(XLEN);

  xlen_t q_add;
  xlen_t q_shl;
  xlen_t q_shr;
  xlen_t src2_alt;
  logic  subtract;
  logic  carry;
  logic  overflow;
  logic  shr_fill;

  logic [0:SHAMT_W][XLEN-1:0] shl_stage;
  logic [0:SHAMT_W][XLEN-1:0] shr_stage;

  // -------------------------------------------------------------------------
  // Adder shared by add, sub and the compares
  // -------------------------------------------------------------------------
  always_comb begin
    subtract = alu.alternate | alu.op[1];          // SLT/SLTU need a - b
    src2_alt = subtract ? ~alu.src2 : alu.src2;
    {carry, q_add} = {1'b0, alu.src1} + {1'b0, src2_alt} + {{XLEN{1'b0}}, subtract};
    overflow = ~(alu.src1[XLEN-1] ^ src2_alt[XLEN-1]) & (q_add[XLEN-1] ^ carry);
  end

  // -------------------------------------------------------------------------
  // Barrel shifters with the largest stage first
  // -------------------------------------------------------------------------
  always_comb begin
    shl_stage[0] = alu.src1;
    for (int s = 0; s < SHAMT_W; s++) begin
      if (alu.src2[SHAMT_W-1-s]) begin
        shl_stage[s+1] = shl_stage[s] << (1 << (SHAMT_W - 1 - s));
      end else begin
        shl_stage[s+1] = shl_stage[s];
      end
    end
    q_shl = shl_stage[SHAMT_W];
  end

  always_comb begin
    logic [2*XLEN-1:0] wide;
    shr_fill = alu.src1[XLEN-1] & alu.alternate;   // Sign fill for SRA
    shr_stage[0] = alu.src1;
    for (int s = 0; s < SHAMT_W; s++) begin
      wide = {{XLEN{shr_fill}}, shr_stage[s]} >> (1 << (SHAMT_W - 1 - s));
      if (alu.src2[SHAMT_W-1-s]) begin
        shr_stage[s+1] = wide[XLEN-1:0];
      end else begin
        shr_stage[s+1] = shr_stage[s];
      end
    end
    q_shr = shr_stage[SHAMT_W];
  end

  // -------------------------------------------------------------------------
  // Result select
  // -------------------------------------------------------------------------
  always_comb begin
    case (alu.op)
      OP_ADD:  alu.q = q_add;
      OP_SLL:  alu.q = q_shl;
      OP_SLT:  alu.q = {{(XLEN-1){1'b0}}, overflow ^ q_add[XLEN-1]};
      OP_SLTU: alu.q = {{(XLEN-1){1'b0}}, ~carry};  // Borrow out
      OP_XOR:  alu.q = alu.src1 ^ alu.src2;
      OP_SR:   alu.q = q_shr;
      OP_OR:   alu.q = alu.src1 | alu.src2;
      OP_AND:  alu.q = alu.src1 & alu.src2;
      default: alu.q = '0;
    endcase
  end

endmodule

//--- rtl/ladybird_alu_if.sv
interface ladybird_alu_if;
  import ladybird_config::*;

  alu_op_t op;
  logic    alternate;                    // Subtract or arithmetic shift
  xlen_t   src1;
  xlen_t   src2;
  xlen_t   q;

  modport decoder (
    output op,
    output alternate,
    output src1,
    output src2
  );

  modport alu (
    input  op,
    input  alternate,
    input  src1,
    input  src2,
    output q
  );

endinterface

//--- rtl/ladybird_config.sv
package ladybird_config;

  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_idx_t;

  // Codes match the RISC-V funct3 field
  typedef enum logic [2:0] {
    OP_ADD  = 3'b000,
    OP_SLL  = 3'b001,
    OP_SLT  = 3'b010,
    OP_SLTU = 3'b011,
    OP_XOR  = 3'b100,
    OP_SR   = 3'b101,                    // Logical or arithmetic by alternate
    OP_OR   = 3'b110,
    OP_AND  = 3'b111
  } alu_op_t;

  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;

  // -------------------------------------------------------------------------
  // Instruction word views
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0]  funct7;
    reg_idx_t    rs2;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_t;

endpackage

//--- rtl/ladybird_control_fsm.sv
module ladybird_control_fsm (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic last,
  output logic clear,
  output logic fetch,
  output logic exec,
  output logic busy,
  output logic done
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FETCH = 2'd1,
    EXEC  = 2'd2
  } state_t;

  state_t state;
  state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_next = FETCH;
        end
      end
      FETCH:   state_next = EXEC;
      EXEC:    state_next = last ? IDLE : FETCH;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      done  <= (state == EXEC) && last;            // One cycle after final EXEC
    end
  end

  // Start is only seen in IDLE, so a pulse while busy is dropped
  assign clear = (state == IDLE) && start;
  assign fetch = (state == FETCH);
  assign exec  = (state == EXEC);
  assign busy  = (state != IDLE);

endmodule

//--- rtl/ladybird_decoder.sv
module ladybird_decoder (
  input  ladybird_config::instr_t   instr,
  input  ladybird_config::xlen_t    rs1_data,
  input  ladybird_config::xlen_t    rs2_data,
  output ladybird_config::reg_idx_t rs1,
  output ladybird_config::reg_idx_t rs2,
  output ladybird_config::reg_idx_t rd,
  output logic                      wr_en,
  ladybird_alu_if.decoder           alu
);
  import ladybird_config::*;

  logic  is_op;
  logic  is_op_imm;
  xlen_t imm_sext;

  // rs1, rd and funct3 sit at the same bits in both views
  assign rs1 = instr.r.rs1;
  assign rs2 = instr.r.rs2;
  assign rd  = instr.r.rd;

  assign is_op     = (instr.r.opcode == OPC_OP);
  assign is_op_imm = (instr.i.opcode == OPC_OP_IMM);

  assign imm_sext = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

  always_comb begin
    alu.op        = alu_op_t'(instr.r.funct3);
    alu.alternate = 1'b0;
    alu.src1      = rs1_data;
    alu.src2      = rs2_data;
    wr_en         = 1'b0;

    if (is_op) begin
      alu.alternate = instr.r.funct7[5];           // SUB, SRA
      wr_en         = 1'b1;
    end else if (is_op_imm) begin
      // No SUBI, so only SRAI takes the alternate bit
      if (alu_op_t'(instr.i.funct3) == OP_SR) begin
        alu.alternate = instr.i.imm12[10];
      end
      alu.src2 = imm_sext;
      wr_en    = 1'b1;
    end
  end

endmodule

//--- rtl/ladybird_exec_top.sv
module ladybird_exec_top #(
  parameter  int IMEM_DEPTH = 16,
  localparam int IDX_W      = $clog2(IMEM_DEPTH),
  localparam int LEN_W      = $clog2(IMEM_DEPTH + 1)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      imem_we,
  input  logic [IDX_W-1:0]          imem_addr,
  input  ladybird_config::instr_t   imem_wdata,
  input  logic                      start,
  input  logic [LEN_W-1:0]          prog_len,
  output logic                      busy,
  output logic                      done,
  input  ladybird_config::reg_idx_t dbg_addr,
  output ladybird_config::xlen_t    dbg_data
);
  import ladybird_config::*;

  logic             clear;
  logic             fetch;
  logic             exec;
  logic             last;
  logic [IDX_W-1:0] index;
  instr_t           instr;
  reg_idx_t         rs1;
  reg_idx_t         rs2;
  reg_idx_t         rd;
  logic             wr_en;
  xlen_t            rs1_data;
  xlen_t            rs2_data;

  ladybird_alu_if alu_bus ();

  // -------------------------------------------------------------------------
  // Sequencing
  // -------------------------------------------------------------------------
  ladybird_control_fsm u_fsm (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .last  (last),
    .clear (clear),
    .fetch (fetch),
    .exec  (exec),
    .busy  (busy),
    .done  (done)
  );

  ladybird_pc_counter #(.IMEM_DEPTH(IMEM_DEPTH)) u_pc (
    .clk   (clk),
    .reset (reset),
    .clear (clear),
    .step  (exec),
    .len   (prog_len),
    .index (index),
    .last  (last)
  );

  ladybird_imem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_wdata),
    .re    (fetch),
    .raddr (index),
    .rdata (instr)
  );

  // -------------------------------------------------------------------------
  // Datapath
  // -------------------------------------------------------------------------
  ladybird_decoder u_decoder (
    .instr    (instr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .wr_en    (wr_en),
    .alu      (alu_bus.decoder)
  );

  ladybird_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .dbg_addr (dbg_addr),
    .we       (exec & wr_en),                      // Write at end of EXEC
    .rd       (rd),
    .wd       (alu_bus.q),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_data (dbg_data)
  );

  ladybird_alu u_alu (
    .alu (alu_bus.alu)
  );

endmodule

//--- rtl/ladybird_imem.sv
module ladybird_imem #(
  parameter  int IMEM_DEPTH = 16,
  localparam int IDX_W      = $clog2(IMEM_DEPTH)
) (
  input  logic                   clk,
  input  logic                   we,
  input  logic [IDX_W-1:0]       waddr,
  input  ladybird_config::instr_t wdata,
  input  logic                   re,
  input  logic [IDX_W-1:0]       raddr,
  output ladybird_config::instr_t rdata
);
  import ladybird_config::*;

  instr_t mem [IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read register doubles as the instruction register
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

//--- rtl/ladybird_pc_counter.sv
module ladybird_pc_counter #(
  parameter  int IMEM_DEPTH = 16,
  localparam int IDX_W      = $clog2(IMEM_DEPTH),
  localparam int LEN_W      = $clog2(IMEM_DEPTH + 1)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  logic             step,
  input  logic [LEN_W-1:0] len,
  output logic [IDX_W-1:0] index,
  output logic             last
);

  logic [LEN_W-1:0] len_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
      len_q <= '0;
    end else if (clear) begin
      index <= '0;
      len_q <= (len == '0) ? LEN_W'(1) : len;     // Zero length runs one
    end else if (step && !last) begin
      index <= index + 1'b1;
    end
  end

  assign last = (LEN_W'(index) == len_q - 1'b1);

endmodule

//--- rtl/ladybird_regfile.sv
module ladybird_regfile (
  input  logic                      clk,
  input  logic                      reset,
  input  ladybird_config::reg_idx_t rs1,
  input  ladybird_config::reg_idx_t rs2,
  input  ladybird_config::reg_idx_t dbg_addr,
  input  logic                      we,
  input  ladybird_config::reg_idx_t rd,
  input  ladybird_config::xlen_t    wd,
  output ladybird_config::xlen_t    rs1_data,
  output ladybird_config::xlen_t    rs2_data,
  output ladybird_config::xlen_t    dbg_data
);
  import ladybird_config::*;

  xlen_t regs [1:31];                             // x0 has no storage

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= wd;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
  assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module ladybird_tb \
  -f ladybird_exec.f -o ladybird_sim

./obj_dir/ladybird_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb/ladybird_tb.sv
module ladybird_tb;
  import ladybird_config::*;

  localparam int IMEM_DEPTH = 16;
  localparam int RUN_LIMIT  = 2 * IMEM_DEPTH + 20;   // Cycles before a run counts as hung

  logic       clk;
  logic       reset;
  logic       imem_we;
  logic [3:0] imem_addr;
  instr_t     imem_wdata;
  logic       start;
  logic [4:0] prog_len;
  logic       busy;
  logic       done;
  reg_idx_t   dbg_addr;
  xlen_t      dbg_data;

  integer seed;
  instr_t prog [IMEM_DEPTH];
  xlen_t  model_regs [32];

  ladybird_exec_top #(.IMEM_DEPTH(IMEM_DEPTH)) u_dut (
    .clk        (clk),
    .reset      (reset),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .start      (start),
    .prog_len   (prog_len),
    .busy       (busy),
    .done       (done),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Helpers and compare tasks
  // ------------------------------------------------------------------------
  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd);
    return instr_t'({f7, rs2, rs1, f3, rd, OPC_OP});
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd);
    return instr_t'({imm, rs1, f3, rd, OPC_OP_IMM});
  endfunction

  task automatic end_in_failure();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_reg(input reg_idx_t idx, input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      $display("ERROR: dbg_data x%0d expected 0x%08h actual 0x%08h", idx, expected, actual);
      end_in_failure();
    end
  endtask

  task automatic check_cycles(input int expected, input int actual);
    if (actual !== expected) begin
      $display("ERROR: done latency expected 0x%0h actual 0x%0h", expected, actual);
      end_in_failure();
    end
  endtask

  // ------------------------------------------------------------------------
  // Reference model that runs one instruction per call
  // ------------------------------------------------------------------------
  task automatic model_step(input instr_t w);
    xlen_t      a;
    xlen_t      b;
    xlen_t      r;
    logic       alt;
    logic [4:0] sh;
    a = model_regs[w.r.rs1];
    if (w.r.opcode == OPC_OP) begin
      b   = model_regs[w.r.rs2];
      alt = w.r.funct7[5];
    end else if (w.i.opcode == OPC_OP_IMM) begin
      b   = {{20{w.i.imm12[11]}}, w.i.imm12};
      alt = (w.i.funct3 == 3'd5) ? w.i.imm12[10] : 1'b0;
    end else begin
      return;                                        // Other opcodes retire as no-ops
    end
    sh = b[4:0];
    case (w.r.funct3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: r = alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (w.r.rd != 5'd0) model_regs[w.r.rd] = r;
  endtask

  function automatic instr_t random_instr();
    logic [2:0]  f3;
    logic [11:0] imm;
    reg_idx_t    rd;
    instr_t      w;
    int          kind;
    kind = pick(10);
    f3   = 3'(pick(8));
    imm  = 12'(pick(4096));
    rd   = (pick(8) == 0) ? 5'd0 : 5'(pick(32));
    if (kind < 5) begin
      w = enc_r({1'b0, (f3 == 3'd0 || f3 == 3'd5) ? imm[10] : 1'b0, 5'd0},
                5'(pick(32)), 5'(pick(32)), f3, rd);
    end else if (kind < 9) begin
      if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
      if (f3 == 3'd5) imm = {1'b0, imm[10], 5'd0, imm[4:0]};   // srli or srai
      w = enc_i(imm, 5'(pick(32)), f3, rd);
    end else begin
      w = instr_t'(pick(32'h7fffffff));
      if (w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_IMM) w.r.opcode = 7'b0000011;
    end
    return w;
  endfunction

  // ------------------------------------------------------------------------
  // Load, run and check one program
  // ------------------------------------------------------------------------
  task automatic run_and_check(input int len_field);
    int n;
    int cycles;
    int poke_at;
    int finished;
    n = (len_field == 0) ? 1 : len_field;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      imem_we    = 1'b1;
      imem_addr  = 4'(i);
      imem_wdata = prog[i];
    end
    @(negedge clk);
    imem_we  = 1'b0;
    start    = 1'b1;
    prog_len = 5'(len_field);
    poke_at  = 1 + pick(2 * n);                      // Extra start while busy
    cycles   = 0;
    finished = 0;
    while (finished == 0) begin
      @(negedge clk);
      start = 1'b0;
      cycles++;
      if (done) begin
        finished = 1;
      end else begin
        if (!busy) begin
          $display("busy went low before done in a run of %0d instructions", n);
          end_in_failure();
        end
        if (cycles > RUN_LIMIT) begin
          $display("Timeout waiting for done after start, %0d cycles", cycles);
          end_in_failure();
        end
        if (cycles == poke_at) begin
          start    = 1'b1;
          prog_len = 5'(pick(17));
        end
      end
    end
    check_cycles(2 * n + 1, cycles);
    @(negedge clk);
    if (done || busy) begin
      $display("done or busy still high one cycle after the done pulse");
      end_in_failure();
    end
    for (int i = 0; i < n; i++) model_step(prog[i]);
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      dbg_addr = 5'(i);
      #1;
      check_reg(5'(i), model_regs[i], dbg_data);
    end
  endtask

  initial begin
    seed       = 25745;
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    start      = 1'b0;
    prog_len   = '0;
    dbg_addr   = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Sign boundary values and compares around them
    prog[0]  = enc_i(12'h001, 5'd0, 3'd0, 5'd1);      // x1 = 1
    prog[1]  = enc_i(12'h01f, 5'd1, 3'd1, 5'd1);      // x1 = 0x80000000
    prog[2]  = enc_i(12'hfff, 5'd0, 3'd0, 5'd2);      // x2 = -1
    prog[3]  = enc_i(12'h001, 5'd2, 3'd5, 5'd2);      // x2 = 0x7fffffff
    prog[4]  = enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3);
    prog[5]  = enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd4);
    prog[6]  = enc_i(12'hfff, 5'd2, 3'd2, 5'd5);
    prog[7]  = enc_i(12'hfff, 5'd1, 3'd3, 5'd6);
    prog[8]  = enc_i(12'h404, 5'd1, 3'd5, 5'd7);      // srai by 4
    prog[9]  = enc_r(7'h00, 5'd2, 5'd2, 3'd0, 5'd8);  // Wraps
    prog[10] = enc_r(7'h20, 5'd2, 5'd0, 3'd0, 5'd9);
    prog[11] = enc_i(12'h800, 5'd0, 3'd0, 5'd10);
    prog[12] = enc_i(12'h005, 5'd2, 3'd0, 5'd0);      // rd is x0
    prog[13] = instr_t'(32'h0000_2003);               // Load opcode
    prog[14] = enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd11);
    prog[15] = enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd12);
    run_and_check(16);

    for (int r = 0; r < 30; r++) begin
      for (int i = 0; i < IMEM_DEPTH; i++) prog[i] = random_instr();
      run_and_check(1 + pick(16));
    end
    prog[0] = random_instr();
    run_and_check(0);

    $display("RESULT: PASS");
    $finish;
  end

endmodule
